// ==== Bender.yml ====
package:
  name: link_test

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/link_test_pkg.sv
      - rtl/pattern_gen.sv
      - rtl/err_flash.sv
      - rtl/ctrl_regs.sv
      - rtl/capture_ram.sv
      - rtl/bus_decode.sv
      - rtl/link_test_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/link_test_properties.sv
      - verif/link_test_tb.sv

// ==== rtl/bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module bus_decode (
	input  wire                            CLK,
	input  wire                            rst_i,
	// Master side
	input  wire                            bus_cyc_i,
	input  wire                            bus_stb_i,
	input  wire link_test_pkg::bus_addr_t  bus_adr_i,
	output logic                           bus_ack_o,
	output link_test_pkg::bus_word_t       bus_dat_o,
	// Register block
	output logic                           reg_stb_o,
	output logic                           reg_sel_stat_o,
	input  wire                            reg_ack_i,
	input  wire link_test_pkg::bus_word_t  reg_dat_i,
	// Capture memory
	output logic                           cap_stb_o,
	output link_test_pkg::cap_addr_t       cap_idx_o,
	input  wire                            cap_ack_i,
	input  wire link_test_pkg::bus_word_t  cap_dat_i
);

	localparam int CAW = `LT_CAP_AW;
	localparam link_test_pkg::bus_addr_t CAP_BASE = `LT_ADR_CAP_BASE;

	logic stb_q;      // Strobe seen last cycle
	logic start;      // First cycle of an access
	logic hit_reg;
	logic hit_cap;
	logic unm_ack_q;  // Ack for unmapped space

	////////////////////
	// Window match

	assign hit_reg = (bus_adr_i == `LT_ADR_CTRL) || (bus_adr_i == `LT_ADR_STAT);
	assign hit_cap = (bus_adr_i[`LT_BUS_AW-1:CAW] == CAP_BASE[`LT_BUS_AW-1:CAW]);

	// Only the first stb cycle starts an access
	assign start = bus_cyc_i && bus_stb_i && !stb_q;

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			stb_q     <= 1'b0;
			unm_ack_q <= 1'b0;
		end else begin
			stb_q     <= bus_cyc_i && bus_stb_i;
			unm_ack_q <= start && !hit_reg && !hit_cap;
		end
	end

	assign reg_stb_o      = start && hit_reg;
	assign reg_sel_stat_o = (bus_adr_i == `LT_ADR_STAT);
	assign cap_stb_o      = start && hit_cap;
	assign cap_idx_o      = bus_adr_i[CAW-1:0];   // Word within window

	////////////////////
	// Return path

	// Address is held until ack, so decode stays valid
	always_comb begin
		if (hit_reg) begin
			bus_ack_o = reg_ack_i;
			bus_dat_o = reg_dat_i;
		end else if (hit_cap) begin
			bus_ack_o = cap_ack_i;
			bus_dat_o = cap_dat_i;
		end else begin
			bus_ack_o = unm_ack_q;
			bus_dat_o = '0;   // Unmapped reads zero
		end
	end

endmodule

`default_nettype wire

// ==== rtl/capture_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module capture_ram (
	input  wire                            CLK,
	input  wire                            rst_i,
	// Control
	input  wire                            run_i,       // Rising edge starts capture
	output logic                           ready_o,     // Memory full
	// Link side
	input  wire link_test_pkg::sample_t    rx_data_i,
	input  wire                            rx_valid_i,
	// Bus read port
	input  wire                            stb_i,
	input  wire link_test_pkg::cap_addr_t  idx_i,
	output link_test_pkg::bus_word_t       dat_o,
	output logic                           ack_o
);

	localparam link_test_pkg::cap_addr_t LAST_IDX =
		link_test_pkg::cap_addr_t'(`LT_CAP_DEPTH - 1);

	link_test_pkg::sample_t    mem [`LT_CAP_DEPTH];
	link_test_pkg::cap_addr_t  wr_ptr_q;
	link_test_pkg::bus_word_t  rd_q;

	logic run_q;      // Run delayed for edge detect
	logic run_rise;
	logic busy_q;     // Capture in progress
	logic ready_q;
	logic wr_en;
	logic ack_q;

	////////////////////
	// Run control

	assign run_rise = run_i && !run_q;
	// New start wins over a pending write
	assign wr_en    = busy_q && rx_valid_i && !run_rise;

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			run_q    <= 1'b0;
			busy_q   <= 1'b0;
			ready_q  <= 1'b0;
			wr_ptr_q <= '0;
		end else begin
			run_q <= run_i;
			if (run_rise) begin
				busy_q   <= 1'b1;
				ready_q  <= 1'b0;   // Old result gone
				wr_ptr_q <= '0;
			end else if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
				if (wr_ptr_q == LAST_IDX) begin
					busy_q  <= 1'b0;   // Idle until next edge
					ready_q <= 1'b1;
				end
			end
		end
	end

	assign ready_o = ready_q;

	////////////////////
	// Storage

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_ptr_q] <= rx_data_i;   // Gaps just wait
	end

	// Bus read, sample zero extended
	always_ff @(posedge CLK) begin
		if (stb_i)
			rd_q <= link_test_pkg::bus_word_t'(mem[idx_i]);
	end

	always_ff @(posedge CLK) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= stb_i;   // Data and ack together
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

endmodule

`default_nettype wire

// ==== rtl/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module ctrl_regs (
	input  wire                           CLK,
	input  wire                           rst_i,
	// Bus target side
	input  wire                           stb_i,        // One cycle access pulse
	input  wire                           sel_stat_i,   // 0 control, 1 status
	input  wire                           we_i,
	input  wire link_test_pkg::bus_word_t dat_i,
	output link_test_pkg::bus_word_t      dat_o,
	output logic                          ack_o,
	// Control fields out
	output link_test_pkg::loop_mode_t     loop_mode_o,
	output logic                          hb_slow_o,
	output logic                          run_o,
	// Status sources
	input  wire                           ready_i,      // Capture done
	input  wire                           aligned_i,    // Byte aligned
	input  wire                           comma_det_i
);

	localparam int LOOP_W = $bits(link_test_pkg::loop_mode_t);

	link_test_pkg::bus_word_t ctrl_q;   // Control register
	link_test_pkg::bus_word_t stat_w;   // Status word, built live
	link_test_pkg::bus_word_t rd_q;     // Read data holding
	logic                     ack_q;

	////////////////////
	// Status assembly

	always_comb begin
		stat_w                   = '0;
		stat_w[`LT_STAT_READY]   = ready_i;
		stat_w[`LT_STAT_COMMA]   = comma_det_i;
		stat_w[`LT_STAT_ALIGNED] = aligned_i;
	end

	////////////////////
	// Write and ack

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			ctrl_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= stb_i;   // Ack follows strobe by one cycle
			// Status is read only
			if (stb_i && we_i && !sel_stat_i)
				ctrl_q <= dat_i;
		end
	end

	// Read data latched with the strobe
	always_ff @(posedge CLK) begin
		if (stb_i)
			rd_q <= sel_stat_i ? stat_w : ctrl_q;
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

	// Field breakout
	assign loop_mode_o = ctrl_q[`LT_CTRL_LOOP_LSB +: LOOP_W];
	assign hb_slow_o   = ctrl_q[`LT_CTRL_HB_SLOW];
	assign run_o       = ctrl_q[`LT_CTRL_RUN];   // Capture start level

endmodule

`default_nettype wire

// ==== rtl/err_flash.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

// Stretches a single cycle error pulse into a visible flash
module err_flash #(
	parameter int FLASH_CYCLES = `LT_FLASH_CYCLES
) (
	input  wire  CLK,
	input  wire  rst_i,
	input  wire  trig_i,   // Error pulse from receiver
	output logic led_o
);

	localparam int CW = $clog2(FLASH_CYCLES + 1);

	logic [CW-1:0] cnt_q;   // Cycles left in flash

	////////////////////
	// Down counter

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (trig_i) begin
			// Retrigger reloads full length
			cnt_q <= CW'(FLASH_CYCLES);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Lit while anything is left
	assign led_o = (cnt_q != '0);

endmodule

`default_nettype wire

// ==== rtl/link_test_config.svh ====
`ifndef LINK_TEST_CONFIG_SVH
`define LINK_TEST_CONFIG_SVH

// Bus and link widths
`define LT_BUS_DW        32
`define LT_BUS_AW        12     // Word address
`define LT_SAMPLE_W      16
`define LT_CNT_W         32

`define LT_COMMA         8'hBC  // K28.5 byte

// Heartbeat taps, sim sized
`define LT_HB_FAST_BIT   7
`define LT_HB_SLOW_BIT   10

`define LT_FLASH_CYCLES  64
`define LT_CAP_DEPTH     64
`define LT_CAP_AW        6

////////////////////
// Address map
`define LT_ADR_CTRL      12'h000
`define LT_ADR_STAT      12'h001
`define LT_ADR_CAP_BASE  12'h100

// Control fields
`define LT_CTRL_LOOP_LSB 0
`define LT_CTRL_HB_SLOW  4
`define LT_CTRL_RUN      8

// Status fields
`define LT_STAT_READY    8
`define LT_STAT_COMMA    30
`define LT_STAT_ALIGNED  31

`endif

// ==== rtl/link_test_pkg.sv ====
`default_nettype none

`include "link_test_config.svh"

package link_test_pkg;

	////////////////////
	// Bus side

	// One data word on the register bus
	typedef logic [`LT_BUS_DW-1:0] bus_word_t;

	// Word address, byte lanes not used
	typedef logic [`LT_BUS_AW-1:0] bus_addr_t;

	////////////////////
	// Link side

	// Received or transmitted 8b10b word pair
	typedef logic [`LT_SAMPLE_W-1:0] sample_t;

	// Transceiver loopback code, 0 is normal operation
	typedef logic [2:0] loop_mode_t;

	// Index into the capture memory
	typedef logic [`LT_CAP_AW-1:0] cap_addr_t;

endpackage

`default_nettype wire

// ==== rtl/link_test_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_test_top (
	input  wire                            CLK,
	input  wire                            rst_i,
	// Register bus
	input  wire                            bus_cyc_i,
	input  wire                            bus_stb_i,
	input  wire                            bus_we_i,
	input  wire link_test_pkg::bus_addr_t  bus_adr_i,
	input  wire link_test_pkg::bus_word_t  bus_dat_i,
	output link_test_pkg::bus_word_t       bus_dat_o,
	output logic                           bus_ack_o,
	// Transceiver receive status and data
	input  wire link_test_pkg::sample_t    rx_data_i,
	input  wire                            rx_valid_i,
	input  wire                            rx_disp_err_i,
	input  wire                            rx_not_in_table_i,
	input  wire                            rx_aligned_i,
	input  wire                            rx_comma_det_i,
	input  wire                            rx_is_comma_i,
	// Transceiver transmit side
	output link_test_pkg::sample_t         tx_data_o,
	output logic                           tx_is_k_o,
	output link_test_pkg::loop_mode_t      loop_mode_o,
	// Front panel
	output logic [3:0]                     led_o
);

	// Decoder to targets
	logic                      reg_stb;
	logic                      reg_sel_stat;
	logic                      reg_ack;
	link_test_pkg::bus_word_t  reg_dat;
	logic                      cap_stb;
	link_test_pkg::cap_addr_t  cap_idx;
	logic                      cap_ack;
	link_test_pkg::bus_word_t  cap_dat;

	// Control and status
	logic hb_slow;
	logic cap_run;
	logic cap_ready;

	// LED sources
	logic hb_led;
	logic disp_led;
	logic table_led;

	bus_decode u_decode (
		.CLK(CLK), .rst_i(rst_i),
		.bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i), .bus_adr_i(bus_adr_i),
		.bus_ack_o(bus_ack_o), .bus_dat_o(bus_dat_o),
		.reg_stb_o(reg_stb), .reg_sel_stat_o(reg_sel_stat),
		.reg_ack_i(reg_ack), .reg_dat_i(reg_dat),
		.cap_stb_o(cap_stb), .cap_idx_o(cap_idx),
		.cap_ack_i(cap_ack), .cap_dat_i(cap_dat)
	);

	ctrl_regs u_regs (
		.CLK(CLK), .rst_i(rst_i),
		.stb_i(reg_stb), .sel_stat_i(reg_sel_stat), .we_i(bus_we_i),
		.dat_i(bus_dat_i), .dat_o(reg_dat), .ack_o(reg_ack),
		.loop_mode_o(loop_mode_o), .hb_slow_o(hb_slow), .run_o(cap_run),
		.ready_i(cap_ready), .aligned_i(rx_aligned_i), .comma_det_i(rx_comma_det_i)
	);

	capture_ram u_cap (
		.CLK(CLK), .rst_i(rst_i),
		.run_i(cap_run), .ready_o(cap_ready),
		.rx_data_i(rx_data_i), .rx_valid_i(rx_valid_i),
		.stb_i(cap_stb), .idx_i(cap_idx), .dat_o(cap_dat), .ack_o(cap_ack)
	);

	pattern_gen u_pattern (
		.CLK(CLK), .rst_i(rst_i), .hb_slow_i(hb_slow),
		.tx_data_o(tx_data_o), .tx_is_k_o(tx_is_k_o), .hb_led_o(hb_led)
	);

	////////////////////
	// Error flashers

	err_flash flash_disp (
		.CLK(CLK), .rst_i(rst_i), .trig_i(rx_disp_err_i), .led_o(disp_led)
	);

	err_flash flash_table (
		.CLK(CLK), .rst_i(rst_i), .trig_i(rx_not_in_table_i), .led_o(table_led)
	);

	// Comma indicator goes straight out
	assign led_o = {rx_is_comma_i, table_led, disp_led, hb_led};

endmodule

`default_nettype wire

// ==== rtl/pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module pattern_gen (
	input  wire                    CLK,
	input  wire                    rst_i,
	input  wire                    hb_slow_i,   // Slow blink select
	output link_test_pkg::sample_t tx_data_o,   // Test word to transmitter
	output logic                   tx_is_k_o,   // Low byte is a K char
	output logic                   hb_led_o     // Heartbeat
);

	// Free running test counter
	logic [`LT_CNT_W-1:0] cnt_q;
	logic                 comma_w;

	////////////////////
	// Counter

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;   // One step per clock
		end
	end

	// Transmit word is the low half of the counter
	assign tx_data_o = cnt_q[`LT_SAMPLE_W-1:0];

	////////////////////
	// Comma flag

	// K flag whenever low byte hits the comma code
	assign comma_w   = (cnt_q[7:0] == `LT_COMMA);
	assign tx_is_k_o = comma_w;

	////////////////////
	// Heartbeat

	always_comb begin
		if (hb_slow_i)
			hb_led_o = cnt_q[`LT_HB_SLOW_BIT];   // Slow blink
		else
			hb_led_o = cnt_q[`LT_HB_FAST_BIT];   // Default after reset
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/link_test_pkg.sv
rtl/pattern_gen.sv
rtl/err_flash.sv
rtl/ctrl_regs.sv
rtl/capture_ram.sv
rtl/bus_decode.sv
rtl/link_test_top.sv
verif/link_test_properties.sv
verif/link_test_tb.sv

// ==== verif/link_test_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module link_test_properties (
	input wire                         CLK,
	input wire                         rst_i,
	input wire                         bus_cyc_i,
	input wire                         bus_stb_i,
	input wire                         bus_ack_o,
	input wire link_test_pkg::sample_t tx_data_o,
	input wire                         tx_is_k_o,
	input wire                         rx_disp_err_i,
	input wire [3:0]                   led_o
);

	int   fail_cnt = 0;   // Read by the testbench at the end
	logic access;

	assign access = bus_cyc_i && bus_stb_i;

	////////////////////
	// Bus handshake

	// Ack in the second cycle of stb
	ack_follows_stb: assert property (@(posedge CLK) disable iff (rst_i)
		$rose(access) |=> bus_ack_o)
		else begin fail_cnt++; $error("ack missing one cycle after stb rose"); end

	ack_one_cycle: assert property (@(posedge CLK) disable iff (rst_i)
		bus_ack_o |=> !bus_ack_o)
		else begin fail_cnt++; $error("ack held longer than one cycle"); end

	// No ack without a pending access
	ack_needs_stb: assert property (@(posedge CLK) disable iff (rst_i)
		bus_ack_o |-> $past(access))
		else begin fail_cnt++; $error("ack without a preceding stb"); end

	////////////////////
	// Comma flag and flasher

	comma_rule: assert property (@(posedge CLK) disable iff (rst_i)
		tx_is_k_o == (tx_data_o[7:0] == `LT_COMMA))
		else begin fail_cnt++; $error("K flag does not match the low byte"); end

	flash_on: assert property (@(posedge CLK) disable iff (rst_i)
		rx_disp_err_i |=> led_o[1] [*`LT_FLASH_CYCLES])
		else begin fail_cnt++; $error("disparity LED dropped early"); end

	// Isolated trigger, LED goes dark right after the full length
	flash_off: assert property (@(posedge CLK) disable iff (rst_i)
		rx_disp_err_i ##1 (!rx_disp_err_i) [*`LT_FLASH_CYCLES] |=> !led_o[1])
		else begin fail_cnt++; $error("disparity LED stayed on too long"); end

endmodule

`default_nettype wire

// ==== verif/link_test_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_test_config.svh"

module link_test_tb;

	localparam int CLK_NS     = 40;
	localparam int ACK_CYCLES = 1;    // Ack seen one edge after stb is sampled
	localparam int ACK_LIMIT  = 16;
	localparam link_test_pkg::bus_word_t RUN_BIT = 32'd1 << `LT_CTRL_RUN;

	logic                      CLK = 1'b0;
	logic                      rst_i;
	logic                      bus_cyc_i, bus_stb_i, bus_we_i;
	link_test_pkg::bus_addr_t  bus_adr_i;
	link_test_pkg::bus_word_t  bus_dat_i;
	link_test_pkg::bus_word_t  bus_dat_o;
	logic                      bus_ack_o;
	link_test_pkg::sample_t    rx_data_i;
	logic                      rx_valid_i, rx_disp_err_i, rx_not_in_table_i;
	logic                      rx_aligned_i, rx_comma_det_i, rx_is_comma_i;
	link_test_pkg::sample_t    tx_data_o;
	logic                      tx_is_k_o;
	link_test_pkg::loop_mode_t loop_mode_o;
	logic [3:0]                led_o;

	// Trace contents
	string       cmd_q[$];
	string       name_q[$];
	logic [31:0] a_q[$];
	logic [31:0] b_q[$];
	int          cap_count   = 0;
	logic        trace_ready = 1'b0;

	int                       bus_errs   = 0;
	int                       mon_errs   = 0;
	int                       proto_errs = 0;
	logic [31:0]              lfsr_q     = 32'h207b0304;
	link_test_pkg::bus_word_t ctrl_last  = '0;          // Last control word written
	link_test_pkg::sample_t   cap_exp [`LT_CAP_DEPTH];   // Samples of the last fresh capture

	link_test_top dut (.*);

	bind link_test_top link_test_properties u_props (
		.CLK(CLK), .rst_i(rst_i), .bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i),
		.bus_ack_o(bus_ack_o), .tx_data_o(tx_data_o), .tx_is_k_o(tx_is_k_o),
		.rx_disp_err_i(rx_disp_err_i), .led_o(led_o)
	);

	initial begin : clock_gen
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	////////////////////
	// Helpers

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v     = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp,
			input logic [31:0] act, input bit from_mon);
		assert (act === exp) else begin
			if (from_mon)
				mon_errs++;
			else
				bus_errs++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// One bus cycle, inputs change on the falling edge
	task automatic bus_access(input string name, input logic we,
			input link_test_pkg::bus_addr_t adr, input link_test_pkg::bus_word_t wdata,
			output link_test_pkg::bus_word_t rdata);
		int cycles;
		@(negedge CLK);
		bus_cyc_i <= 1'b1;
		bus_stb_i <= 1'b1;
		bus_we_i  <= we;
		bus_adr_i <= adr;
		bus_dat_i <= wdata;
		@(negedge CLK);
		cycles = 1;
		while (!bus_ack_o && cycles < ACK_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		rdata = bus_dat_o;   // Valid while ack is high
		assert (bus_ack_o) else begin
			proto_errs++;
			$display("%s: the bus gave no ack within %0d cycles", name, ACK_LIMIT);
		end
		if (bus_ack_o)
			check_eq({name, "_ack_latency"}, ACK_CYCLES, cycles, 1'b0);
		bus_cyc_i <= 1'b0;
		bus_stb_i <= 1'b0;
		bus_we_i  <= 1'b0;
	endtask

	task automatic bus_write(input string name, input link_test_pkg::bus_addr_t adr,
			input link_test_pkg::bus_word_t data);
		link_test_pkg::bus_word_t rd;
		bus_access(name, 1'b1, adr, data, rd);
		if (adr == `LT_ADR_CTRL)
			ctrl_last = data;
	endtask

	// Status reads get fresh random link levels on top of the expected word
	task automatic check_read(input string name, input link_test_pkg::bus_addr_t adr,
			input link_test_pkg::bus_word_t exp);
		link_test_pkg::bus_word_t rd;
		link_test_pkg::bus_word_t exp_full;
		logic [1:0]               lv;
		exp_full = exp;
		if (adr == `LT_ADR_STAT) begin
			lv = 2'(rand_bits(2));
			@(negedge CLK);
			rx_aligned_i   <= lv[1];
			rx_comma_det_i <= lv[0];
			exp_full[`LT_STAT_ALIGNED] = lv[1];
			exp_full[`LT_STAT_COMMA]   = lv[0];
		end
		bus_access(name, 1'b0, adr, '0, rd);
		check_eq(name, exp_full, rd, 1'b0);
	endtask

	////////////////////
	// Capture run

	task automatic run_capture(input string name, input logic fresh);
		int                     n;
		logic                   valid;
		link_test_pkg::sample_t sample;
		if (fresh) begin
			bus_write({name, "_run_low"}, `LT_ADR_CTRL, ctrl_last & ~RUN_BIT);
			bus_write({name, "_run_high"}, `LT_ADR_CTRL, ctrl_last | RUN_BIT);
			check_read({name, "_busy"}, `LT_ADR_STAT, '0);   // Ready cleared by the edge
		end
		n = 0;
		while (n < `LT_CAP_DEPTH) begin
			@(negedge CLK);
			valid  = (rand_bits(2) != 0);   // About one gap in four
			sample = link_test_pkg::sample_t'(rand_bits(`LT_SAMPLE_W));
			rx_valid_i        <= valid;
			rx_data_i         <= sample;
			rx_disp_err_i     <= (rand_bits(5) == 0);
			rx_not_in_table_i <= (rand_bits(5) == 0);
			rx_is_comma_i     <= (rand_bits(1) != 0);
			if (valid) begin
				if (fresh)
					cap_exp[n] = sample;
				n++;
			end
		end
		@(negedge CLK);
		rx_valid_i        <= 1'b0;
		rx_disp_err_i     <= 1'b0;
		rx_not_in_table_i <= 1'b0;
		check_read({name, "_ready"}, `LT_ADR_STAT, 32'd1 << `LT_STAT_READY);
		// A repeat run must leave the old words in place
		for (int i = 0; i < `LT_CAP_DEPTH; i++)
			check_read($sformatf("%s_word%0d", name, i),
				link_test_pkg::bus_addr_t'(`LT_ADR_CAP_BASE + i), {16'h0, cap_exp[i]});
	endtask

	////////////////////
	// Reference monitor

	initial begin : monitor
		link_test_pkg::sample_t   tx_exp;     // Reference count from reset
		link_test_pkg::bus_word_t ctrl_exp;   // Control word seen on the bus
		int                       disp_left;
		int                       table_left;
		logic                     hb_exp;
		forever begin
			@(negedge CLK);
			if (rst_i) begin
				check_eq("reset_tx", 0, tx_data_o, 1'b1);
				check_eq("reset_leds", 0, led_o[2:0], 1'b1);
				check_eq("reset_ack", 0, bus_ack_o, 1'b1);
				tx_exp     = '0;
				ctrl_exp   = '0;
				disp_left  = 0;
				table_left = 0;
			end else begin
				if (bus_stb_i && bus_we_i && bus_ack_o && bus_adr_i == `LT_ADR_CTRL)
					ctrl_exp = bus_dat_i;   // Takes effect with ack
				tx_exp = link_test_pkg::sample_t'(tx_exp + 1'b1);   // One step per clock
				check_eq("tx_count", tx_exp, tx_data_o, 1'b1);
				check_eq("tx_comma", tx_data_o[7:0] == `LT_COMMA, tx_is_k_o, 1'b1);
				hb_exp = ctrl_exp[`LT_CTRL_HB_SLOW] ? tx_data_o[`LT_HB_SLOW_BIT]
				                                    : tx_data_o[`LT_HB_FAST_BIT];
				check_eq("heartbeat", hb_exp, led_o[0], 1'b1);
				check_eq("loopback", ctrl_exp[`LT_CTRL_LOOP_LSB +: 3], loop_mode_o, 1'b1);
				// Trigger seen here was sampled on the last rising edge
				disp_left  = rx_disp_err_i ? `LT_FLASH_CYCLES
				                           : (disp_left > 0 ? disp_left - 1 : 0);
				table_left = rx_not_in_table_i ? `LT_FLASH_CYCLES
				                               : (table_left > 0 ? table_left - 1 : 0);
				check_eq("led_disp", disp_left != 0, led_o[1], 1'b1);
				check_eq("led_table", table_left != 0, led_o[2], 1'b1);
				check_eq("led_comma", rx_is_comma_i, led_o[3], 1'b1);
			end
		end
	end

	initial begin : watchdog
		longint limit_cycles;
		wait (trace_ready);
		limit_cycles = cmd_q.size() * 200 + cap_count * `LT_CAP_DEPTH * 4;
		#(limit_cycles * CLK_NS);
		$display("Watchdog expired after %0d cycles, the test did not finish", limit_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////
	// Main sequence

	initial begin : main
		int          fd;
		int          n;
		string       line;
		string       cmd;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		int          total;
		rst_i             = 1'b1;
		bus_cyc_i         = 1'b0;
		bus_stb_i         = 1'b0;
		bus_we_i          = 1'b0;
		bus_adr_i         = '0;
		bus_dat_i         = '0;
		rx_data_i         = '0;
		rx_valid_i        = 1'b0;
		rx_disp_err_i     = 1'b0;
		rx_not_in_table_i = 1'b0;
		rx_aligned_i      = 1'b0;
		rx_comma_det_i    = 1'b0;
		rx_is_comma_i     = 1'b0;

		fd = $fopen("verif/link_test_trace.txt", "r");
		assert (fd != 0) else begin
			proto_errs++;
			$display("Cannot open the trace file verif/link_test_trace.txt");
		end
		if (fd != 0) begin
			while ($fgets(line, fd)) begin
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;   // Blank or comment
				n = $sscanf(line, "%s %s %h %h", cmd, name, a, b);
				if (n != 4) begin
					proto_errs++;
					$display("Trace line has the wrong number of fields: %s", line);
					continue;
				end
				cmd_q.push_back(cmd);
				name_q.push_back(name);
				a_q.push_back(a);
				b_q.push_back(b);
				if (cmd == "CAP")
					cap_count++;
			end
			$fclose(fd);
		end
		trace_ready = 1'b1;

		repeat (2) @(negedge CLK);
		rst_i <= 1'b0;

		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"W":     bus_write(name_q[i], a_q[i][`LT_BUS_AW-1:0], b_q[i]);
				"R":     check_read(name_q[i], a_q[i][`LT_BUS_AW-1:0], b_q[i]);
				"CAP":   run_capture(name_q[i], b_q[i][0]);
				default: begin
					proto_errs++;
					$display("Unknown trace command %s in %s", cmd_q[i], name_q[i]);
				end
			endcase
		end

		repeat (`LT_FLASH_CYCLES + 4) @(negedge CLK);   // Let flashers run out
		total = bus_errs + mon_errs + proto_errs + dut.u_props.fail_cnt;
		$display("Error counts: bus %0d, monitor %0d, protocol %0d, assertion %0d",
			bus_errs, mon_errs, proto_errs, dut.u_props.fail_cnt);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/link_test_trace.txt ====
# cmd name addr(hex) value(hex); W writes value, R reads and compares with value
# CAP value 1 starts a fresh capture, 0 repeats it with run held high
# Status reads also expect the aligned and comma levels driven at read time
R   ctrl_reset       000 00000000
R   stat_reset       001 00000000
R   unmapped_low     002 00000000
R   unmapped_top     fff 00000000
R   unmapped_past    140 00000000
W   ctrl_loop5       000 00000005
R   ctrl_loop5_rd    000 00000005
W   ctrl_mixed       000 a5a50e07
R   ctrl_mixed_rd    000 a5a50e07
W   stat_ro          001 ffffffff
R   stat_ro_rd       001 00000000
R   ctrl_after_stat  000 a5a50e07
W   unmapped_wr      0ff 12345678
R   unmapped_wr_rd   0ff 00000000
W   hb_slow          000 00000012
R   hb_slow_rd       000 00000012
CAP cap_first        000 00000001
CAP cap_again        000 00000000
R   stat_ready       001 00000100
W   hb_fast          000 00000003
R   stat_ready_held  001 00000100
CAP cap_second       000 00000001
R   ctrl_end         000 00000103
R   stat_end         001 00000100
